// File: project.f
+incdir+include
src/tlp_pkg.sv
src/slv_pkg.sv
src/tlp_ifs.sv
src/tlp_rx_parser.sv
src/rx_credit_return.sv
src/slave_sequencer.sv
src/cpl_transmitter.sv
src/pcie_tlp_top.sv
tests/tb_pcie_tlp.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_pcie_tlp -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Compile step returned an error"
	exit 1
fi

output=$(./obj_dir/Vtb_pcie_tlp)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation returned an error status"
	exit 1
fi

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// File: src/cpl_transmitter.sv
`timescale 1ns/1ns

module cpl_transmitter (
	input  logic                       pcie_clk,
	input  logic                       sys_rst,
	input  logic [7:0]                 bus_num_i,
	input  logic [4:0]                 dev_num_i,
	input  logic [2:0]                 func_num_i,
	cpl_if.tx                          cpl,
	output logic                       tx_req_o,
	output logic                       tx_st_o,
	output logic                       tx_end_o,
	output logic [tlp_pkg::WORD_W-1:0] tx_data_o,
	input  logic                       tx_rdy_i
);
	import tlp_pkg::*;

	typedef enum logic [2:0] {
		T_IDLE,
		T_WAIT,
		T_H1,
		T_H2,
		T_H3,
		T_H4,
		T_H5,
		T_DATA
	} tx_state_t;

	tx_state_t       state;
	logic [ID_W-1:0] cpl_id;

	assign cpl_id = {bus_num_i, dev_num_i, func_num_i};

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= T_IDLE;
			tx_req_o <= 1'b0;
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			cpl.data_ready <= 1'b0;
		end else begin
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			case (state)
				T_IDLE: begin
					if (cpl.hdr_valid) begin
						tx_req_o <= 1'b1;
						state <= T_WAIT;
					end
				end
				T_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o <= 1'b0;
						tx_st_o <= 1'b1;
						tx_data_o <= {1'b0, FMT_CPL_DATA, TYPE_CPL, 1'b0, {TC_W{1'b0}}, 4'h0};
						state <= T_H1;
					end
				end
				T_H1: begin
					tx_data_o <= {2'b00, {ATTR_W{1'b0}}, 2'b00, cpl.length};
					state <= T_H2;
				end
				T_H2: begin
					tx_data_o <= cpl_id;
					// Sequencer read pipeline is three cycles deep
					cpl.data_ready <= 1'b1;
					state <= T_H3;
				end
				T_H3: begin
					tx_data_o <= {3'b000, 1'b0, cpl.bcount};
					state <= T_H4;
				end
				T_H4: begin
					tx_data_o <= cpl.reqid;
					state <= T_H5;
				end
				T_H5: begin
					tx_data_o <= {cpl.tag, 1'b0, cpl.lower_addr};
					state <= T_DATA;
				end
				T_DATA: begin
					tx_data_o <= cpl.data;
					if (cpl.done) begin
						tx_end_o <= 1'b1;
						cpl.data_ready <= 1'b0;
						state <= T_IDLE;
					end
				end
				default: state <= T_IDLE;
			endcase
		end
	end

endmodule

// File: src/pcie_tlp_top.sv
`timescale 1ns/1ns

module pcie_tlp_top #(
	parameter int SLV_ADDR_W = 19
) (
	input  logic                           pcie_clk,
	input  logic                           sys_rst,
	// Management
	input  logic [tlp_pkg::BAR_W-1:0]      bar_hit_i,
	input  logic [7:0]                     bus_num_i,
	input  logic [4:0]                     dev_num_i,
	input  logic [2:0]                     func_num_i,
	// Receive link
	input  logic                           rx_st_i,
	input  logic                           rx_end_i,
	input  logic [tlp_pkg::WORD_W-1:0]     rx_data_i,
	// Transmit link
	output logic                           tx_req_o,
	input  logic                           tx_rdy_i,
	output logic                           tx_st_o,
	output logic                           tx_end_o,
	output logic [tlp_pkg::WORD_W-1:0]     tx_data_o,
	// Receive credits
	output logic [7:0]                     pd_num_o,
	output logic                           ph_cr_o,
	output logic                           pd_cr_o,
	output logic                           nph_cr_o,
	output logic                           npd_cr_o,
	// Slave bus
	output logic [tlp_pkg::BAR_W-1:0]      slv_bar_o,
	output logic                           slv_ce_o,
	output logic                           slv_we_o,
	output logic [SLV_ADDR_W-1:0]          slv_adr_o,
	output logic [slv_pkg::SLV_DATA_W-1:0] slv_dat_o,
	output slv_pkg::slv_sel_t              slv_sel_o,
	input  logic [slv_pkg::SLV_DATA_W-1:0] slv_dat_i
);

	req_if req ();
	cpl_if cpl ();

	// ------------------------------------------------------------
	// Receive side
	// ------------------------------------------------------------
	tlp_rx_parser u_parser (
		.pcie_clk,
		.sys_rst,
		.rx_st_i,
		.rx_end_i,
		.rx_data_i,
		.req      (req.parser)
	);

	rx_credit_return u_credit (
		.pcie_clk,
		.sys_rst,
		.bar_hit_i,
		.req      (req.consumer),
		.ph_cr_o,
		.pd_cr_o,
		.nph_cr_o,
		.npd_cr_o,
		.pd_num_o
	);

	// ------------------------------------------------------------
	// Slave access and completion
	// ------------------------------------------------------------
	slave_sequencer #(
		.SLV_ADDR_W (SLV_ADDR_W)
	) u_seq (
		.pcie_clk,
		.sys_rst,
		.bar_hit_i,
		.req       (req.consumer),
		.cpl       (cpl.seq),
		.slv_bar_o,
		.slv_ce_o,
		.slv_we_o,
		.slv_adr_o,
		.slv_dat_o,
		.slv_sel_o,
		.slv_dat_i
	);

	cpl_transmitter u_tx (
		.pcie_clk,
		.sys_rst,
		.bus_num_i,
		.dev_num_i,
		.func_num_i,
		.cpl       (cpl.tx),
		.tx_req_o,
		.tx_st_o,
		.tx_end_o,
		.tx_data_o,
		.tx_rdy_i
	);

endmodule

// File: src/rx_credit_return.sv
`timescale 1ns/1ns

module rx_credit_return (
	input  logic                      pcie_clk,
	input  logic                      sys_rst,
	input  logic [tlp_pkg::BAR_W-1:0] bar_hit_i,
	req_if.consumer                   req,
	output logic                      ph_cr_o,
	output logic                      pd_cr_o,
	output logic                      nph_cr_o,
	output logic                      npd_cr_o,
	output logic [7:0]                pd_num_o
);
	import tlp_pkg::*;

	logic [7:0] pd_need;

	// Payload dwords in units of 4, rounded up
	assign pd_need = req.hdr.length[LEN_W-1:2] + {7'd0, |req.hdr.length[1:0]};

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= 8'h00;
		end else begin
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= 8'h00;
			if (req.pkt_end) begin
				case (req.hdr.kind)
					TLP_MEM, TLP_MEM_LOCK: begin
						if (bar_hit_i != '0) begin
							if (req.hdr.fmt[1]) begin
								ph_cr_o <= 1'b1;
								pd_cr_o <= 1'b1;
								pd_num_o <= pd_need;
							end else begin
								nph_cr_o <= 1'b1;
							end
						end
					end
					TLP_IO, TLP_CFG0, TLP_CFG1: begin
						nph_cr_o <= 1'b1;
						npd_cr_o <= req.hdr.fmt[1];
					end
					TLP_MSG: begin
						ph_cr_o <= 1'b1;
						if (req.hdr.fmt[1]) begin
							pd_cr_o <= 1'b1;
							pd_num_o <= pd_need;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: src/slave_sequencer.sv
`timescale 1ns/1ns

module slave_sequencer #(
	parameter int SLV_ADDR_W = 19
) (
	input  logic                          pcie_clk,
	input  logic                          sys_rst,
	input  logic [tlp_pkg::BAR_W-1:0]     bar_hit_i,
	req_if.consumer                       req,
	cpl_if.seq                            cpl,
	output logic [tlp_pkg::BAR_W-1:0]     slv_bar_o,
	output logic                          slv_ce_o,
	output logic                          slv_we_o,
	output logic [SLV_ADDR_W-1:0]         slv_adr_o,
	output logic [slv_pkg::SLV_DATA_W-1:0] slv_dat_o,
	output slv_pkg::slv_sel_t             slv_sel_o,
	input  logic [slv_pkg::SLV_DATA_W-1:0] slv_dat_i
);
	import tlp_pkg::*;
	import slv_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRITE,
		S_RD_HDR,
		S_RD_DATA
	} seq_state_t;

	seq_state_t          state;
	logic [SLV_ADDR_W-1:0] start_adr;
	logic [SLV_ADDR_W-1:0] hw_adr;
	logic [LEN_W:0]      hw_idx;
	logic [LEN_W:0]      hw_end;
	logic [BE_W-1:0]     lane_be;
	slv_sel_t            lane_sel;
	logic [1:0]          first_lo;
	logic [1:0]          first_hi;
	logic [1:0]          last_hi;
	logic [BCOUNT_W-1:0] bcount_calc;
	logic                rd_last;
	logic                cap_q;
	logic                cap_last;

	function automatic logic [1:0] be_low(input logic [BE_W-1:0] be);
		logic [1:0] pos;
		pos = 2'd0;
		for (int i = BE_W - 1; i >= 0; i--) begin
			if (be[i])
				pos = 2'(i);
		end
		return pos;
	endfunction

	function automatic logic [1:0] be_high(input logic [BE_W-1:0] be);
		logic [1:0] pos;
		pos = 2'd0;
		for (int i = 0; i < BE_W; i++) begin
			if (be[i])
				pos = 2'(i);
		end
		return pos;
	endfunction

	// Halfword address, dword aligned
	assign start_adr = {req.hdr.addr[SLV_ADDR_W-2:0], 1'b0};
	assign hw_end = {cpl.length, 1'b0};

	assign first_lo = be_low(req.hdr.first_be);
	assign first_hi = be_high(req.hdr.first_be);
	assign last_hi = be_high(req.hdr.last_be);

	always_comb begin
		if (req.hdr.length == LEN_W'(1))
			bcount_calc = BCOUNT_W'(first_hi) - BCOUNT_W'(first_lo) + BCOUNT_W'(1);
		else
			bcount_calc = {req.hdr.length, 2'b00} - BCOUNT_W'(first_lo)
				- BCOUNT_W'(2'd3 - last_hi);
	end

	// Byte enables of the dword that holds halfword hw_idx
	always_comb begin
		if (hw_idx[LEN_W:1] == '0)
			lane_be = req.hdr.first_be;
		else if (hw_idx[LEN_W:1] == req.hdr.length - LEN_W'(1))
			lane_be = req.hdr.last_be;
		else
			lane_be = '1;
		lane_sel = hw_idx[0] ? {lane_be[2], lane_be[3]} : {lane_be[0], lane_be[1]};
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			slv_bar_o <= '0;
			slv_ce_o <= 1'b0;
			slv_we_o <= 1'b0;
			slv_sel_o <= '0;
			cpl.hdr_valid <= 1'b0;
			cpl.done <= 1'b0;
			rd_last <= 1'b0;
			cap_q <= 1'b0;
			cap_last <= 1'b0;
		end else begin
			slv_ce_o <= 1'b0;
			slv_we_o <= 1'b0;
			cpl.done <= 1'b0;
			rd_last <= 1'b0;
			// Read data returns one cycle after the strobe
			cap_q <= slv_ce_o & ~slv_we_o;
			cap_last <= rd_last;
			if (cap_q) begin
				cpl.data <= slv_dat_i;
				cpl.done <= cap_last;
			end
			case (state)
				S_IDLE: begin
					if (req.hdr_valid && req.hdr.kind == TLP_MEM) begin
						slv_bar_o <= bar_hit_i;
						hw_adr <= start_adr;
						hw_idx <= '0;
						state <= req.hdr.fmt[1] ? S_WRITE : S_RD_HDR;
					end
				end
				S_WRITE: begin
					if (req.wr_valid) begin
						slv_ce_o <= 1'b1;
						slv_we_o <= 1'b1;
						slv_adr_o <= hw_adr;
						slv_dat_o <= req.wr_data;
						slv_sel_o <= lane_sel;
						hw_adr <= hw_adr + 1'b1;
						hw_idx <= hw_idx + 1'b1;
					end
					if (req.pkt_end)
						state <= S_IDLE;
				end
				S_RD_HDR: begin
					cpl.length <= req.hdr.length;
					cpl.bcount <= bcount_calc;
					cpl.lower_addr <= {req.hdr.addr[4:0], first_lo};
					cpl.reqid <= req.hdr.reqid;
					cpl.tag <= req.hdr.tag;
					cpl.hdr_valid <= 1'b1;
					state <= S_RD_DATA;
				end
				S_RD_DATA: begin
					if (cpl.data_ready) begin
						cpl.hdr_valid <= 1'b0;
						if (hw_idx != hw_end) begin
							slv_ce_o <= 1'b1;
							slv_adr_o <= hw_adr;
							slv_sel_o <= 2'b11;
							rd_last <= (hw_idx + 1'b1 == hw_end);
							hw_adr <= hw_adr + 1'b1;
							hw_idx <= hw_idx + 1'b1;
						end
					end
					if (cap_q && cap_last)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: src/slv_pkg.sv
package slv_pkg;

	// Slave bus data path
	localparam int SLV_DATA_W = 16;

	// One enable per byte lane, upper lane in bit 1
	typedef logic [1:0] slv_sel_t;

endpackage

// File: src/tlp_ifs.sv
`timescale 1ns/1ns

// Parsed request and payload stream from the receive parser
interface req_if;
	import tlp_pkg::*;

	req_hdr_t          hdr;
	logic              hdr_valid;
	logic              wr_valid;
	logic [WORD_W-1:0] wr_data;
	logic              pkt_end;

	modport parser (output hdr, hdr_valid, wr_valid, wr_data, pkt_end);
	modport consumer (input hdr, hdr_valid, wr_valid, wr_data, pkt_end);
endinterface

// Completion fields and read data toward the transmitter
interface cpl_if;
	import tlp_pkg::*;

	logic                hdr_valid;
	logic [LEN_W-1:0]    length;
	logic [BCOUNT_W-1:0] bcount;
	logic [6:0]          lower_addr;
	logic [REQID_W-1:0]  reqid;
	logic [TAG_W-1:0]    tag;
	logic [WORD_W-1:0]   data;
	logic                done;
	logic                data_ready;

	modport seq (
		output hdr_valid, length, bcount, lower_addr, reqid, tag, data, done,
		input  data_ready
	);
	modport tx (
		input  hdr_valid, length, bcount, lower_addr, reqid, tag, data, done,
		output data_ready
	);
endinterface

// File: src/tlp_pkg.sv
package tlp_pkg;

	// Link and header field widths
	localparam int WORD_W   = 16;
	localparam int FMT_W    = 2;
	localparam int TYPE_W   = 5;
	localparam int TC_W     = 3;
	localparam int ATTR_W   = 2;
	localparam int LEN_W    = 10;
	localparam int BE_W     = 4;
	localparam int TAG_W    = 8;
	localparam int REQID_W  = 16;
	localparam int ID_W     = 16;
	localparam int ADDR_W   = 62;
	localparam int BAR_W    = 7;
	localparam int BCOUNT_W = 12;

	// Completion with data
	localparam logic [FMT_W-1:0]  FMT_CPL_DATA = 2'b10;
	localparam logic [TYPE_W-1:0] TYPE_CPL     = 5'b01010;

	typedef enum logic [2:0] {
		TLP_MEM,
		TLP_MEM_LOCK,
		TLP_IO,
		TLP_CFG0,
		TLP_CFG1,
		TLP_MSG,
		TLP_CPL,
		TLP_CPL_LOCK
	} tlp_kind_t;

	// addr holds byte address bits 63:2
	typedef struct packed {
		logic [FMT_W-1:0]   fmt;
		logic [TYPE_W-1:0]  typ;
		tlp_kind_t          kind;
		logic [LEN_W-1:0]   length;
		logic [REQID_W-1:0] reqid;
		logic [TAG_W-1:0]   tag;
		logic [BE_W-1:0]    last_be;
		logic [BE_W-1:0]    first_be;
		logic [ADDR_W-1:0]  addr;
	} req_hdr_t;

endpackage

// File: src/tlp_rx_parser.sv
`timescale 1ns/1ns

module tlp_rx_parser (
	input  logic                       pcie_clk,
	input  logic                       sys_rst,
	input  logic                       rx_st_i,
	input  logic                       rx_end_i,
	input  logic [tlp_pkg::WORD_W-1:0] rx_data_i,
	req_if.parser                      req
);
	import tlp_pkg::*;

	typedef enum logic [3:0] {
		RX_IDLE,
		RX_LEN,
		RX_REQID,
		RX_TAG,
		RX_ADDR3,
		RX_ADDR2,
		RX_ADDR1,
		RX_ADDR0,
		RX_DATA,
		RX_SKIP
	} rx_state_t;

	rx_state_t state;
	tlp_kind_t kind_w;

	// Format and type decode of header word 0
	always_comb begin
		if (rx_data_i[12]) begin
			kind_w = TLP_MSG;
		end else if (!rx_data_i[11]) begin
			case (rx_data_i[10:8])
				3'b000:  kind_w = TLP_MEM;
				3'b001:  kind_w = TLP_MEM_LOCK;
				3'b010:  kind_w = TLP_IO;
				3'b100:  kind_w = TLP_CFG0;
				default: kind_w = TLP_CFG1;
			endcase
		end else if (rx_data_i[8]) begin
			kind_w = TLP_CPL_LOCK;
		end else begin
			kind_w = TLP_CPL;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= RX_IDLE;
			req.hdr_valid <= 1'b0;
			req.wr_valid <= 1'b0;
			req.pkt_end <= 1'b0;
		end else begin
			req.hdr_valid <= 1'b0;
			req.wr_valid <= 1'b0;
			req.pkt_end <= rx_end_i;
			case (state)
				RX_IDLE: begin
					if (rx_st_i) begin
						req.hdr.fmt <= rx_data_i[14:13];
						req.hdr.typ <= rx_data_i[12:8];
						req.hdr.kind <= kind_w;
						state <= RX_LEN;
					end
				end
				RX_LEN: begin
					req.hdr.length <= rx_data_i[LEN_W-1:0];
					// Completions carry no request fields
					state <= req.hdr.typ[3] ? RX_SKIP : RX_REQID;
				end
				RX_REQID: begin
					req.hdr.reqid <= rx_data_i;
					state <= RX_TAG;
				end
				RX_TAG: begin
					req.hdr.tag <= rx_data_i[15:8];
					req.hdr.last_be <= rx_data_i[7:4];
					req.hdr.first_be <= rx_data_i[3:0];
					if (req.hdr.fmt[0]) begin
						state <= RX_ADDR3;
					end else begin
						req.hdr.addr[61:30] <= '0;
						state <= RX_ADDR1;
					end
				end
				RX_ADDR3: begin
					req.hdr.addr[61:46] <= rx_data_i;
					state <= RX_ADDR2;
				end
				RX_ADDR2: begin
					req.hdr.addr[45:30] <= rx_data_i;
					state <= RX_ADDR1;
				end
				RX_ADDR1: begin
					req.hdr.addr[29:14] <= rx_data_i;
					state <= RX_ADDR0;
				end
				RX_ADDR0: begin
					req.hdr.addr[13:0] <= rx_data_i[15:2];
					req.hdr_valid <= 1'b1;
					state <= RX_DATA;
				end
				RX_DATA: begin
					req.wr_valid <= 1'b1;
					req.wr_data <= rx_data_i;
				end
				default: ;
			endcase
			if (rx_end_i)
				state <= RX_IDLE;
		end
	end

endmodule

// File: include/tb_tlp_ref.svh
`ifndef TB_TLP_REF_SVH
`define TB_TLP_REF_SVH

// 32-bit LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic int be_lo_pos(input logic [3:0] be);
	for (int i = 0; i < 4; i++) begin
		if (be[i])
			return i;
	end
	return 0;
endfunction

function automatic int be_hi_pos(input logic [3:0] be);
	for (int i = 3; i >= 0; i--) begin
		if (be[i])
			return i;
	end
	return 0;
endfunction

function automatic logic [11:0] ref_bcount(input logic [9:0] len, input logic [3:0] fbe,
		input logic [3:0] lbe);
	if (len == 10'd1)
		return 12'(be_hi_pos(fbe) - be_lo_pos(fbe) + 1);
	return 12'(4 * int'(len) - be_lo_pos(fbe) - (3 - be_hi_pos(lbe)));
endfunction

function automatic logic [6:0] ref_lower_addr(input logic [31:0] addr, input logic [3:0] fbe);
	return {addr[6:2], 2'(be_lo_pos(fbe))};
endfunction

// Packed as {ph, pd, nph, npd, pd_num}
function automatic logic [11:0] ref_credits(input tlp_pkg::tlp_kind_t kind,
		input logic [1:0] fmt, input logic [6:0] bar_hit, input logic [9:0] len);
	logic [7:0] dw;
	dw = 8'((int'(len) + 3) / 4);
	case (kind)
		tlp_pkg::TLP_MEM, tlp_pkg::TLP_MEM_LOCK: begin
			if (bar_hit == 7'd0)
				return 12'h000;
			return fmt[1] ? {4'b1100, dw} : {4'b0010, 8'h00};
		end
		tlp_pkg::TLP_IO, tlp_pkg::TLP_CFG0, tlp_pkg::TLP_CFG1:
			return {3'b001, fmt[1], 8'h00};
		tlp_pkg::TLP_MSG:
			return fmt[1] ? {4'b1100, dw} : {4'b1000, 8'h00};
		default:
			return 12'h000;
	endcase
endfunction

function automatic logic [1:0] ref_lane_sel(input int k, input logic [9:0] len,
		input logic [3:0] fbe, input logic [3:0] lbe);
	logic [3:0] be;
	if (k / 2 == 0)
		be = fbe;
	else if (k / 2 == int'(len) - 1)
		be = lbe;
	else
		be = 4'hf;
	return (k % 2 != 0) ? {be[2], be[3]} : {be[0], be[1]};
endfunction

task automatic expect_equal(input string name, input logic [63:0] exp,
		input logic [63:0] act);
	if (act !== exp) begin
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
		stop_run("A checked value did not match");
	end
endtask

`endif

// File: tests/tb_pcie_tlp.sv
`timescale 1ns/1ns

module tb_pcie_tlp;
	import tlp_pkg::*;

	localparam int NUM_PKTS = 19;
	localparam int RST_CYCLES = 5;
	localparam int CYCLE_LIMIT = 40 * NUM_PKTS + RST_CYCLES;

	logic        pcie_clk;
	logic        sys_rst;
	logic [6:0]  bar_hit_i;
	logic [7:0]  bus_num_i;
	logic [4:0]  dev_num_i;
	logic [2:0]  func_num_i;
	logic        rx_st_i;
	logic        rx_end_i;
	logic [15:0] rx_data_i;
	logic        tx_req_o;
	logic        tx_rdy_i;
	logic        tx_st_o;
	logic        tx_end_o;
	logic [15:0] tx_data_o;
	logic [7:0]  pd_num_o;
	logic        ph_cr_o;
	logic        pd_cr_o;
	logic        nph_cr_o;
	logic        npd_cr_o;
	logic [6:0]  slv_bar_o;
	logic        slv_ce_o;
	logic        slv_we_o;
	logic [18:0] slv_adr_o;
	logic [15:0] slv_dat_o;
	logic [1:0]  slv_sel_o;
	logic [15:0] slv_dat_i;

	logic [31:0] lfsr;
	logic [15:0] mem [int];
	// Expectation queues filled by the packet driver
	logic [11:0] cr_exp [$];
	int          cr_due [$];
	logic [43:0] wr_exp [$];
	logic [17:0] tx_exp [$];

	int   cycle;
	logic pkt_seen;
	logic tx_active;
	logic tx_waiting;
	logic rdy_prev;

	`include "tb_tlp_ref.svh"

	pcie_tlp_top #(
		.SLV_ADDR_W (19)
	) DUT (
		.*
	);

	initial begin
		pcie_clk = 1'b0;
		forever #20 pcie_clk = ~pcie_clk;
	end

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic next_rand(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Fill pattern of unwritten slave memory
	function automatic logic [15:0] mem_value(input logic [18:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return a[15:0] ^ {a[18:16], 13'h0a5b} ^ 16'h3c5a;
	endfunction

	task automatic put_word(input logic st, input logic en, input logic [15:0] d);
		rx_st_i = st;
		rx_end_i = en;
		rx_data_i = d;
		@(posedge pcie_clk);
		#2;
	endtask

	task automatic send_req(input tlp_kind_t kind, input logic [1:0] fmt,
			input logic [4:0] typ, input logic [9:0] len, input logic [6:0] bar);
		logic [31:0] r;
		logic [63:0] addr;
		logic [3:0]  fbe;
		logic [3:0]  lbe;
		logic [15:0] reqid;
		logic [7:0]  tag;
		logic [15:0] pay [$];
		logic [18:0] start;
		int          nhw;
		nhw = 2 * int'(len);
		next_rand(32, r);
		addr = {32'd0, r[31:2], 2'b00};
		if (fmt[0]) begin
			next_rand(32, r);
			addr[63:32] = r;
		end
		next_rand(8, r);
		fbe = r[3:0];
		lbe = (len == 10'd1) ? 4'h0 : r[7:4];
		next_rand(24, r);
		reqid = r[15:0];
		tag = r[23:16];
		if (fmt[1]) begin
			for (int k = 0; k < nhw; k++) begin
				next_rand(16, r);
				pay.push_back(r[15:0]);
			end
		end
		bar_hit_i = bar;
		cr_exp.push_back(ref_credits(kind, fmt, bar, len));
		start = {addr[19:2], 1'b0};
		if (kind == TLP_MEM && fmt[1]) begin
			for (int k = 0; k < nhw; k++)
				wr_exp.push_back({bar, 19'(start + 19'(k)), pay[k],
					ref_lane_sel(k, len, fbe, lbe)});
		end
		if (kind == TLP_MEM && !fmt[1]) begin
			tx_exp.push_back({2'b10, 1'b0, FMT_CPL_DATA, TYPE_CPL, 8'h00});
			tx_exp.push_back({2'b00, 6'd0, len});
			tx_exp.push_back({2'b00, bus_num_i, dev_num_i, func_num_i});
			tx_exp.push_back({2'b00, 4'h0, ref_bcount(len, fbe, lbe)});
			tx_exp.push_back({2'b00, reqid});
			tx_exp.push_back({2'b00, tag, 1'b0, ref_lower_addr(addr[31:0], fbe)});
			for (int k = 0; k < nhw; k++)
				tx_exp.push_back({1'b0, k == nhw - 1, mem_value(19'(start + 19'(k)))});
		end
		put_word(1'b1, 1'b0, {1'b0, fmt, typ, 8'h00});
		put_word(1'b0, 1'b0, {6'd0, len});
		put_word(1'b0, 1'b0, reqid);
		put_word(1'b0, 1'b0, {tag, lbe, fbe});
		if (fmt[0]) begin
			put_word(1'b0, 1'b0, addr[63:48]);
			put_word(1'b0, 1'b0, addr[47:32]);
		end
		put_word(1'b0, 1'b0, addr[31:16]);
		put_word(1'b0, pay.size() == 0, addr[15:0]);
		for (int k = 0; k < pay.size(); k++)
			put_word(1'b0, k == pay.size() - 1, pay[k]);
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
	endtask

	task automatic wait_idle();
		while (cr_exp.size() != 0 || wr_exp.size() != 0 || tx_exp.size() != 0) begin
			@(posedge pcie_clk);
			#2;
		end
		repeat (3) @(posedge pcie_clk);
		#2;
	endtask

	// ----------------------------------------------------------
	// Slave memory and link ready models
	// ----------------------------------------------------------
	always @(posedge pcie_clk) begin
		logic [18:0] a;
		logic [15:0] old;
		if (slv_ce_o) begin
			a = slv_adr_o;
			old = mem_value(a);
			if (slv_we_o) begin
				mem[int'(a)] = {slv_sel_o[1] ? slv_dat_o[15:8] : old[15:8],
					slv_sel_o[0] ? slv_dat_o[7:0] : old[7:0]};
			end else begin
				#2 slv_dat_i = old;
			end
		end
	end

	always @(posedge pcie_clk) begin
		logic [31:0] d;
		if (tx_req_o && !tx_rdy_i) begin
			next_rand(3, d);
			repeat (d) @(posedge pcie_clk);
			#2 tx_rdy_i = 1'b1;
			@(posedge pcie_clk);
			#2 tx_rdy_i = 1'b0;
		end
	end

	// ----------------------------------------------------------
	// Comparing process
	// ----------------------------------------------------------
	always @(posedge pcie_clk) begin
		logic [11:0] cr_act;
		logic [43:0] w;
		cycle++;
		if (cycle > CYCLE_LIMIT)
			stop_run("Timeout: the run did not finish within the cycle limit");
		cr_act = {ph_cr_o, pd_cr_o, nph_cr_o, npd_cr_o, pd_num_o};
		if (rx_st_i)
			pkt_seen = 1'b1;
		if (!sys_rst) begin
			if (!pkt_seen)
				expect_equal("reset state", 64'd0, {tx_req_o, tx_st_o, tx_end_o,
					slv_ce_o, slv_we_o, slv_sel_o});
			if (cr_due.size() != 0 && cycle == cr_due[0]) begin
				void'(cr_due.pop_front());
				expect_equal("credits", cr_exp.pop_front(), cr_act);
			end else begin
				expect_equal("credits idle", 64'd0, cr_act);
			end
			if (rx_end_i)
				cr_due.push_back(cycle + 2);
			if (slv_ce_o && slv_we_o) begin
				if (wr_exp.size() == 0)
					stop_run("Slave write strobe with no write expected");
				w = wr_exp.pop_front();
				expect_equal("slave write", w,
					{slv_bar_o, slv_adr_o, slv_dat_o, slv_sel_o});
			end
			if (tx_st_o && !rdy_prev)
				stop_run("Completion started without tx_rdy");
			if (tx_waiting && !tx_req_o && !rdy_prev)
				stop_run("tx_req dropped before tx_rdy");
			if (tx_req_o)
				tx_waiting = 1'b1;
			if (tx_st_o)
				tx_waiting = 1'b0;
			if (tx_st_o || tx_end_o || tx_active) begin
				if (tx_exp.size() == 0)
					stop_run("Transmit word with no completion expected");
				expect_equal("completion word", tx_exp.pop_front(),
					{tx_st_o, tx_end_o, tx_data_o});
				if (tx_st_o)
					tx_active = 1'b1;
				if (tx_end_o)
					tx_active = 1'b0;
			end
		end
		rdy_prev = tx_rdy_i;
	end

	initial begin
		logic [31:0] r;
		logic [9:0]  len;
		lfsr = 32'h8722_b186;
		cycle = 0;
		pkt_seen = 1'b0;
		tx_active = 1'b0;
		tx_waiting = 1'b0;
		rdy_prev = 1'b0;
		sys_rst = 1'b1;
		bar_hit_i = '0;
		bus_num_i = 8'h3a;
		dev_num_i = 5'h11;
		func_num_i = 3'h5;
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
		rx_data_i = '0;
		tx_rdy_i = 1'b0;
		slv_dat_i = '0;
		repeat (RST_CYCLES) @(posedge pcie_clk);
		#2 sys_rst = 1'b0;
		repeat (3) @(posedge pcie_clk);
		#2;

		// Credit rules per packet kind
		send_req(TLP_MEM, 2'b00, 5'h00, 10'd2, 7'h01);
		wait_idle();
		send_req(TLP_MEM, 2'b10, 5'h00, 10'd3, 7'h02);
		wait_idle();
		send_req(TLP_MEM, 2'b10, 5'h00, 10'd1, 7'h00);
		wait_idle();
		send_req(TLP_IO, 2'b10, 5'h02, 10'd1, 7'h00);
		wait_idle();
		send_req(TLP_CFG0, 2'b10, 5'h04, 10'd1, 7'h00);
		wait_idle();
		send_req(TLP_MSG, 2'b11, 5'h10, 10'd4, 7'h00);
		wait_idle();
		send_req(TLP_CPL, 2'b10, 5'h0a, 10'd2, 7'h00);
		wait_idle();

		// Random writes and reads, random tx_rdy delays
		for (int i = 0; i < 4; i++) begin
			next_rand(5, r);
			len = 10'(r[1:0]) + 10'd1;
			send_req(TLP_MEM, 2'b10, 5'h00, len, 7'h01 << (r[4:2] % 7));
			wait_idle();
			next_rand(5, r);
			len = 10'(r[1:0]) + 10'd1;
			send_req(TLP_MEM, 2'b11, 5'h00, len, 7'h01 << (r[4:2] % 7));
			wait_idle();
			next_rand(2, r);
			len = 10'(r[1:0]) + 10'd1;
			send_req(TLP_MEM, 2'b00, 5'h00, len, 7'h04);
			wait_idle();
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
